//--- hw/tester_pkg.sv
`default_nettype none

package tester_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths and types
	//////////////////////////////////////////////////////////////////////

	localparam int WORD_W = 128;
	localparam int SIG_W = 126;

	typedef logic [WORD_W-1:0] word_t;
	// A vector word carries the vector in its low bits.
	typedef logic [SIG_W-1:0] sig_t;
	typedef logic [6:0] edge_t;
	typedef logic [7:0] cycle_len_t;

	// Opcodes sit in bits 7 to 0 of a command word.
	typedef enum logic [7:0] {
		CMD_INPUT   = 8'h02,
		CMD_CONFIG  = 8'h05,
		CMD_EXECUTE = 8'h06
	} cmd_t;

	typedef enum logic [7:0] {
		RPL_ACK        = 8'hAA,
		RPL_UNKNOWN    = 8'hEE,
		RPL_NO_VECTORS = 8'hE0,
		RPL_FULL       = 8'hE1
	} reply_t;

	//////////////////////////////////////////////////////////////////////
	// Configuration word layout and defaults
	//////////////////////////////////////////////////////////////////////

	localparam int CFG_LEAD_LSB = 8;
	localparam int CFG_TRAIL_LSB = 24;
	localparam int CFG_LEN_LSB = 32;

	localparam edge_t DEF_LEADING_EDGE = 7'd6;
	localparam edge_t DEF_TRAILING_EDGE = 7'd14;
	localparam cycle_len_t DEF_CYCLE_LENGTH = 8'd30;

	// Chip select closes this many clocks ahead of the trailing edge.
	// The level translators need the margin.
	localparam cycle_len_t CS_LEAD = 8'd3;

endpackage

`default_nettype wire

//--- hw/cycle_timer.sv
`timescale 1ns/1ns
`default_nettype none

module cycle_timer import tester_pkg::*; (
	input  logic       CLK,
	input  logic       rst,
	input  logic       run,
	input  edge_t      leading_edge,
	input  edge_t      trailing_edge,
	input  cycle_len_t cycle_length,
	output logic       sram_cs_n,
	output logic       prefetch,
	output logic       cycle_end
);

	cycle_len_t count;
	cycle_len_t count_next;
	cycle_len_t cs_start;
	cycle_len_t cs_stop;
	logic       cs_window;

	assign prefetch = run && (count == cycle_length - 8'd2);
	assign cycle_end = run && (count == cycle_length - 8'd1);

	// Count for the coming clock. It is zero while idle, so the first
	// cycle of a test already sees its window.
	assign count_next = (run && !cycle_end) ? count + 8'd1 : 8'd0;

	assign cs_start = {1'b0, leading_edge};
	assign cs_stop = {1'b0, trailing_edge} - CS_LEAD;

	always_ff @(posedge CLK) begin
		if (rst) begin
			count <= 8'd0;
			cs_window <= 1'b0;
		end else begin
			count <= count_next;
			cs_window <= (count_next >= cs_start) && (count_next < cs_stop);
		end
	end

	// chip select only inside a running cycle
	assign sram_cs_n = !(cs_window && run);

	// A valid configuration closes the window before the cycle ends.
	assert property (@(posedge CLK) disable iff (rst) (!run || cycle_end) |-> sram_cs_n);

endmodule

`default_nettype wire

//--- hw/test_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module test_sequencer import tester_pkg::*; (
	input  logic       CLK,
	input  logic       rst,
	input  logic       start,
	input  sig_t       rd_data,
	input  logic       more_to_read,
	input  edge_t      leading_edge,
	input  edge_t      trailing_edge,
	input  cycle_len_t cycle_length,
	output logic       rd_en,
	output logic       rewind,
	output logic       done,
	output sig_t       signals,
	output logic       sram_cs_n
);

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_FETCH,
		SEQ_RUN,
		SEQ_FINISH
	} seq_state_t;

	seq_state_t state;
	logic       first_rd;
	logic       next_ready;
	logic       run;
	logic       prefetch;
	logic       cycle_end;

	// The next vector is read one clock before the cycle ends, so it is
	// ready on the store output at cycle_end.
	assign rd_en = first_rd || (state == SEQ_RUN && prefetch && more_to_read);
	assign done = (state == SEQ_FINISH);
	assign rewind = (state == SEQ_FINISH);

	//////////////////////////////////////////////////////////////////////
	// Sequencing FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (rst) begin
			state <= SEQ_IDLE;
			first_rd <= 1'b0;
			next_ready <= 1'b0;
			run <= 1'b0;
			signals <= '0;
		end else begin
			case (state)
				SEQ_IDLE: begin
					if (start) begin
						first_rd <= 1'b1;
						state <= SEQ_FETCH;
					end
				end
				SEQ_FETCH: begin
					// First clock issues the read, second loads the result.
					first_rd <= 1'b0;
					if (!first_rd) begin
						signals <= rd_data;
						run <= 1'b1;
						state <= SEQ_RUN;
					end
				end
				SEQ_RUN: begin
					if (prefetch) begin
						next_ready <= more_to_read;
					end
					if (cycle_end) begin
						next_ready <= 1'b0;
						if (next_ready) begin
							signals <= rd_data;
						end else begin
							// Last cycle is over. Release the bus.
							signals <= '0;
							run <= 1'b0;
							state <= SEQ_FINISH;
						end
					end
				end
				SEQ_FINISH: begin
					state <= SEQ_IDLE;
				end
				default: begin
					state <= SEQ_IDLE;
				end
			endcase
		end
	end

	cycle_timer cycle_timer_i (
		.CLK           (CLK),
		.rst           (rst),
		.run           (run),
		.leading_edge  (leading_edge),
		.trailing_edge (trailing_edge),
		.cycle_length  (cycle_length),
		.sram_cs_n     (sram_cs_n),
		.prefetch      (prefetch),
		.cycle_end     (cycle_end)
	);

endmodule

`default_nettype wire

//--- hw/vector_store.sv
`timescale 1ns/1ns
`default_nettype none

module vector_store import tester_pkg::*; #(
	parameter int DEPTH = 16
) (
	input  logic CLK,
	input  logic rst,
	input  logic wr_en,
	input  sig_t wr_data,
	input  logic rd_en,
	input  logic rewind,
	output sig_t rd_data,
	output logic full,
	output logic empty,
	output logic more_to_read
);

	// Slot address width, and pointer width that can also hold DEPTH.
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int PW = $clog2(DEPTH + 1);

	typedef logic [PW-1:0] ptr_t;

	sig_t mem [DEPTH];
	ptr_t wr_ptr;
	ptr_t rd_ptr;

	assign full = (wr_ptr == ptr_t'(DEPTH));
	assign empty = (wr_ptr == '0);
	assign more_to_read = (rd_ptr < wr_ptr);

	//////////////////////////////////////////////////////////////////////
	// Pointers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			// Rewind keeps the contents so the same test can run again.
			if (rewind) begin
				rd_ptr <= '0;
			end else if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (wr_en) begin
			mem[wr_ptr[AW-1:0]] <= wr_data;
		end
	end

	// Registered read. Data follows rd_en by one clock.
	always_ff @(posedge CLK) begin
		if (rd_en) begin
			rd_data <= mem[rd_ptr[AW-1:0]];
		end
	end

	// The sequencer only fetches what the decoder has written.
	assert property (@(posedge CLK) disable iff (rst) rd_en |-> more_to_read);

endmodule

`default_nettype wire

//--- hw/command_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module command_decoder import tester_pkg::*; (
	input  logic       CLK,
	input  logic       rst,
	input  logic       rx_valid,
	input  word_t      rx_word,
	input  logic       full,
	input  logic       empty,
	input  logic       done,
	output logic       tx_valid,
	output reply_t     tx_code,
	output logic       wr_en,
	output sig_t       wr_data,
	output logic       start,
	output edge_t      leading_edge,
	output edge_t      trailing_edge,
	output cycle_len_t cycle_length
);

	typedef enum logic [1:0] {
		DEC_IDLE,
		DEC_VECTOR,
		DEC_TEST
	} dec_state_t;

	dec_state_t state;
	cmd_t       opcode;
	logic       reply_now;
	reply_t     reply;

	assign opcode = cmd_t'(rx_word[7:0]);

	// Reply selection. Exactly one reply per host word, none while a test runs.
	always_comb begin
		reply_now = 1'b0;
		reply = RPL_ACK;
		case (state)
			DEC_IDLE: begin
				if (rx_valid) begin
					reply_now = 1'b1;
					case (opcode)
						CMD_INPUT, CMD_CONFIG: begin
							reply = RPL_ACK;
						end
						CMD_EXECUTE: begin
							// A non-empty store defers the ACK until the test ends.
							reply = RPL_NO_VECTORS;
							reply_now = empty;
						end
						default: begin
							reply = RPL_UNKNOWN;
						end
					endcase
				end
			end
			DEC_VECTOR: begin
				reply_now = rx_valid;
				reply = full ? RPL_FULL : RPL_ACK;
			end
			DEC_TEST: begin
				reply_now = done;
			end
			default: begin
				reply_now = 1'b0;
			end
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Control state and cycle configuration
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (rst) begin
			state <= DEC_IDLE;
			tx_valid <= 1'b0;
			wr_en <= 1'b0;
			start <= 1'b0;
			leading_edge <= DEF_LEADING_EDGE;
			trailing_edge <= DEF_TRAILING_EDGE;
			cycle_length <= DEF_CYCLE_LENGTH;
		end else begin
			tx_valid <= reply_now;
			wr_en <= 1'b0;
			start <= 1'b0;
			case (state)
				DEC_IDLE: begin
					if (rx_valid) begin
						case (opcode)
							CMD_INPUT: begin
								state <= DEC_VECTOR;
							end
							CMD_CONFIG: begin
								leading_edge <= rx_word[CFG_LEAD_LSB +: $bits(edge_t)];
								trailing_edge <= rx_word[CFG_TRAIL_LSB +: $bits(edge_t)];
								cycle_length <= rx_word[CFG_LEN_LSB +: $bits(cycle_len_t)];
							end
							CMD_EXECUTE: begin
								if (!empty) begin
									start <= 1'b1;
									state <= DEC_TEST;
								end
							end
							default: begin
								state <= DEC_IDLE;
							end
						endcase
					end
				end
				DEC_VECTOR: begin
					// Vector is dropped when there is no free slot.
					if (rx_valid) begin
						wr_en <= !full;
						state <= DEC_IDLE;
					end
				end
				DEC_TEST: begin
					if (done) begin
						state <= DEC_IDLE;
					end
				end
				default: begin
					state <= DEC_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (reply_now) begin
			tx_code <= reply;
		end
		if (state == DEC_VECTOR && rx_valid) begin
			wr_data <= rx_word[SIG_W-1:0];
		end
	end

	// The store flag is sampled a cycle before the write lands.
	assert property (@(posedge CLK) disable iff (rst) wr_en |-> !full);

endmodule

`default_nettype wire

//--- hw/vector_tester_top.sv
`timescale 1ns/1ns
`default_nettype none

module vector_tester_top import tester_pkg::*; #(
	parameter int DEPTH = 16
) (
	input  logic   CLK,
	input  logic   rst,
	input  logic   rx_valid,
	input  word_t  rx_word,
	output logic   tx_valid,
	output reply_t tx_code,
	output sig_t   signals,
	output logic   sram_cs_n
);

	// Decoder to store.
	logic       wr_en;
	sig_t       wr_data;
	logic       full;
	logic       empty;

	// Sequencer to store.
	logic       rd_en;
	logic       rewind;
	sig_t       rd_data;
	logic       more_to_read;

	// Decoder to sequencer.
	logic       start;
	logic       done;
	edge_t      leading_edge;
	edge_t      trailing_edge;
	cycle_len_t cycle_length;

	command_decoder command_decoder_i (
		.CLK           (CLK),
		.rst           (rst),
		.rx_valid      (rx_valid),
		.rx_word       (rx_word),
		.full          (full),
		.empty         (empty),
		.done          (done),
		.tx_valid      (tx_valid),
		.tx_code       (tx_code),
		.wr_en         (wr_en),
		.wr_data       (wr_data),
		.start         (start),
		.leading_edge  (leading_edge),
		.trailing_edge (trailing_edge),
		.cycle_length  (cycle_length)
	);

	vector_store #(
		.DEPTH (DEPTH)
	) vector_store_i (
		.CLK          (CLK),
		.rst          (rst),
		.wr_en        (wr_en),
		.wr_data      (wr_data),
		.rd_en        (rd_en),
		.rewind       (rewind),
		.rd_data      (rd_data),
		.full         (full),
		.empty        (empty),
		.more_to_read (more_to_read)
	);

	test_sequencer test_sequencer_i (
		.CLK           (CLK),
		.rst           (rst),
		.start         (start),
		.rd_data       (rd_data),
		.more_to_read  (more_to_read),
		.leading_edge  (leading_edge),
		.trailing_edge (trailing_edge),
		.cycle_length  (cycle_length),
		.rd_en         (rd_en),
		.rewind        (rewind),
		.done          (done),
		.signals       (signals),
		.sram_cs_n     (sram_cs_n)
	);

endmodule

`default_nettype wire

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD = 8,
	parameter int RESET_CYCLES = 10
) (
	input  logic rst_req,
	output logic CLK,
	output logic rst
);

	int unsigned cycles_left = RESET_CYCLES;

	initial CLK = 1'b0;

	always #(PERIOD / 2) CLK = ~CLK;

	// Reset holds for a fixed count of rising edges, at start and on request.
	assign rst = (cycles_left != 0);

	always @(posedge CLK) begin
		if (rst_req) begin
			cycles_left <= RESET_CYCLES;
		end else if (cycles_left != 0) begin
			cycles_left <= cycles_left - 1;
		end
	end

endmodule

`default_nettype wire

//--- sim/tb_checker.sv
`timescale 1ns/1ns
`default_nettype none

module tb_checker import tester_pkg::*; #(
	parameter int DEPTH = 8,
	parameter int TIMEOUT = 1000
) (
	input  logic   CLK,
	input  logic   tx_valid,
	input  reply_t tx_code,
	input  sig_t   signals,
	input  logic   sram_cs_n,
	output int     err_count,
	output logic   timed_out
);

	sig_t exp_vec [DEPTH];
	int   test_count;
	int   test_errs;
	logic reply_claimed;

	initial begin
		err_count = 0;
		timed_out = 1'b0;
		test_count = 0;
		test_errs = 0;
		reply_claimed = 1'b0;
	end

	task automatic count_error();
		err_count++;
		test_errs++;
	endtask

	task automatic report_value(input string name, input logic [127:0] expected,
			input logic [127:0] actual);
		$display("ERR %s: expected %0h, actual %0h", name, expected, actual);
		count_error();
	endtask

	task automatic store_expected(input int idx, input sig_t vec);
		exp_vec[idx] = vec;
	endtask

	task automatic end_test(input string name);
		test_count++;
		if (test_errs == 0) begin
			$display("PASS %s", name);
		end else begin
			$display("FAIL %s with %0d errors", name, test_errs);
		end
		test_errs = 0;
	endtask

	task automatic print_counts();
		$display("Tests run: %0d, errors: %0d", test_count, err_count);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Reply checks
	//////////////////////////////////////////////////////////////////////

	// Every reply pulse must have been taken by one of the checks below.
	always @(posedge CLK) begin
		if (tx_valid === 1'b1 && !reply_claimed) begin
			$display("Reply %0h came without a matching word", tx_code);
			count_error();
		end
		reply_claimed = 1'b0;
	end

	// A reply is due one clock after the word was taken.
	task automatic expect_reply(input string name, input reply_t code);
		int   waited;
		logic found;
		waited = 0;
		found = 1'b0;
		while (!found && waited < TIMEOUT) begin
			@(negedge CLK);
			waited++;
			found = (tx_valid === 1'b1);
		end
		if (!found) begin
			$display("%s: no reply within %0d cycles", name, TIMEOUT);
			timed_out = 1'b1;
			count_error();
		end else begin
			reply_claimed = 1'b1;
			if (waited != 1) begin
				$display("%s: reply came %0d cycles after the word, not 1", name, waited);
				count_error();
			end
			if (tx_code !== code) begin
				report_value(name, 128'(code), 128'(tx_code));
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Bus checks
	//////////////////////////////////////////////////////////////////////

	task automatic check_idle(input string name, input int cycles);
		int   k;
		logic bad;
		bad = 1'b0;
		for (k = 0; k < cycles; k++) begin
			@(negedge CLK);
			if (!bad && signals !== '0) begin
				report_value(name, '0, 128'(signals));
				bad = 1'b1;
			end
			if (!bad && sram_cs_n !== 1'b1) begin
				$display("%s: chip select active while idle", name);
				count_error();
				bad = 1'b1;
			end
		end
	endtask

	// Follows one execute from the accepting edge to its closing ACK.
	task automatic check_run(input string name, input int count, input int lead,
			input int trail, input int len);
		int   i;
		int   k;
		int   lows;
		int   runs;
		int   first_low;
		logic prev_low;
		logic vec_bad;
		for (k = 0; k < 3; k++) begin
			@(negedge CLK);
			if (signals !== '0 || sram_cs_n !== 1'b1) begin
				$display("%s: bus active before the first vector", name);
				count_error();
			end
		end
		for (i = 0; i < count; i++) begin
			lows = 0;
			runs = 0;
			first_low = 0;
			prev_low = 1'b0;
			vec_bad = 1'b0;
			for (k = 0; k < len; k++) begin
				@(negedge CLK);
				if (!vec_bad && signals !== exp_vec[i]) begin
					report_value($sformatf("%s vector %0d", name, i), 128'(exp_vec[i]),
						128'(signals));
					vec_bad = 1'b1;
				end
				if (sram_cs_n === 1'b0) begin
					lows++;
					if (!prev_low) begin
						runs++;
						first_low = k;
					end
				end
				prev_low = (sram_cs_n === 1'b0);
			end
			// Window spans leading edge up to trailing edge less the lead.
			if (lows != trail - int'(CS_LEAD) - lead) begin
				report_value($sformatf("%s cs length %0d", name, i),
					128'(trail - int'(CS_LEAD) - lead), 128'(lows));
			end
			if (runs != 1) begin
				$display("%s: chip select opened %0d times in cycle %0d", name, runs, i);
				count_error();
			end else if (first_low != lead) begin
				report_value($sformatf("%s cs start %0d", name, i), 128'(lead),
					128'(first_low));
			end
		end
		@(negedge CLK);
		if (signals !== '0 || sram_cs_n !== 1'b1) begin
			$display("%s: bus not released after the last vector", name);
			count_error();
		end
		expect_reply(name, RPL_ACK);
	endtask

endmodule

`default_nettype wire

//--- sim/tb_vector_tester.sv
`timescale 1ns/1ns
`default_nettype none

module tb_vector_tester import tester_pkg::*; ();

	localparam int DEPTH = 8;
	localparam int TIMEOUT = 1000;
	localparam int unsigned SEED = 32'hb0b61859;

	logic   CLK;
	logic   rst;
	logic   rst_req;
	logic   rx_valid;
	word_t  rx_word;
	logic   tx_valid;
	reply_t tx_code;
	sig_t   signals;
	logic   sram_cs_n;
	int     err_count;
	logic   timed_out;
	logic   reset_stuck;

	// Model of the store contents and the active cycle timing.
	sig_t model_vec [$];
	int   model_lead;
	int   model_trail;
	int   model_len;

	tb_clock_gen #(
		.PERIOD       (8),
		.RESET_CYCLES (10)
	) tb_clock_gen_i (
		.rst_req (rst_req),
		.CLK     (CLK),
		.rst     (rst)
	);

	vector_tester_top #(
		.DEPTH (DEPTH)
	) vector_tester_top_i (
		.CLK       (CLK),
		.rst       (rst),
		.rx_valid  (rx_valid),
		.rx_word   (rx_word),
		.tx_valid  (tx_valid),
		.tx_code   (tx_code),
		.signals   (signals),
		.sram_cs_n (sram_cs_n)
	);

	tb_checker #(
		.DEPTH   (DEPTH),
		.TIMEOUT (TIMEOUT)
	) checker_i (
		.CLK       (CLK),
		.tx_valid  (tx_valid),
		.tx_code   (tx_code),
		.signals   (signals),
		.sram_cs_n (sram_cs_n),
		.err_count (err_count),
		.timed_out (timed_out)
	);

	//////////////////////////////////////////////////////////////////////
	// Host side stimulus
	//////////////////////////////////////////////////////////////////////

	function automatic word_t random_word();
		return {$urandom, $urandom, $urandom, $urandom};
	endfunction

	task automatic send_word(input word_t w);
		@(posedge CLK);
		rx_valid <= 1'b1;
		rx_word <= w;
		@(posedge CLK);
		rx_valid <= 1'b0;
		rx_word <= '0;
	endtask

	// Power-on cycle timing, empty store.
	task automatic model_reset();
		model_vec.delete();
		model_lead = 6;
		model_trail = 14;
		model_len = 30;
	endtask

	task automatic wait_reset_release();
		int n;
		n = 0;
		@(negedge CLK);
		while (rst && n < TIMEOUT) begin
			@(negedge CLK);
			n++;
		end
		if (rst) begin
			$display("Reset did not release within %0d cycles", TIMEOUT);
			reset_stuck = 1'b1;
		end
	endtask

	task automatic apply_reset();
		@(posedge CLK);
		rst_req <= 1'b1;
		@(posedge CLK);
		rst_req <= 1'b0;
		wait_reset_release();
		model_reset();
	endtask

	task automatic load_vector(input string name);
		word_t w;
		w = random_word();
		w[7:0] = CMD_INPUT;
		send_word(w);
		checker_i.expect_reply(name, RPL_ACK);
		w = random_word();
		send_word(w);
		if (model_vec.size() < DEPTH) begin
			checker_i.expect_reply(name, RPL_ACK);
			model_vec.push_back(w[SIG_W-1:0]);
		end else begin
			checker_i.expect_reply(name, RPL_FULL);
		end
	endtask

	// Random timing with lead < trail - 3 < len. Widest opens the window to the end.
	task automatic send_config(input string name, input logic widest);
		word_t w;
		int    len;
		int    stop;
		int    lead;
		len = 6 + int'($urandom % 35);
		stop = widest ? len - 1 : 1 + int'($urandom % (len - 1));
		lead = int'($urandom % stop);
		w = random_word();
		w[7:0] = CMD_CONFIG;
		w[CFG_LEAD_LSB +: 7] = edge_t'(lead);
		w[CFG_TRAIL_LSB +: 7] = edge_t'(stop + 3);
		w[CFG_LEN_LSB +: 8] = cycle_len_t'(len);
		send_word(w);
		checker_i.expect_reply(name, RPL_ACK);
		model_lead = lead;
		model_trail = stop + 3;
		model_len = len;
	endtask

	task automatic execute(input string name);
		word_t w;
		int    i;
		w = random_word();
		w[7:0] = CMD_EXECUTE;
		for (i = 0; i < model_vec.size(); i++) begin
			checker_i.store_expected(i, model_vec[i]);
		end
		send_word(w);
		if (model_vec.size() == 0) begin
			checker_i.expect_reply(name, RPL_NO_VECTORS);
		end else begin
			checker_i.check_run(name, model_vec.size(), model_lead, model_trail, model_len);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	task automatic run_tests();
		word_t w;
		int    n;
		wait_reset_release();
		if (reset_stuck) return;
		checker_i.check_idle("after_reset", 20);
		checker_i.end_test("after_reset");
		for (n = 0; n < 4; n++) begin
			w = random_word();
			if (w[7:0] == 8'h02 || w[7:0] == 8'h05 || w[7:0] == 8'h06) begin
				w[7] = 1'b1;
			end
			send_word(w);
			checker_i.expect_reply("unknown_opcode", RPL_UNKNOWN);
		end
		checker_i.end_test("unknown_opcode");
		execute("empty_execute");
		checker_i.end_test("empty_execute");
		if (timed_out) return;
		for (n = 0; n < DEPTH + 3; n++) begin
			load_vector("load_vectors");
		end
		checker_i.end_test("load_vectors");
		if (timed_out) return;
		send_config("apply_vectors", 1'b0);
		execute("apply_vectors");
		checker_i.end_test("apply_vectors");
		if (timed_out) return;
		send_config("chip_select_window", 1'b1);
		execute("chip_select_window");
		checker_i.end_test("chip_select_window");
		if (timed_out) return;
		send_config("replay_new_config", 1'b0);
		execute("replay_new_config");
		checker_i.check_idle("replay_new_config", 40);
		checker_i.end_test("replay_new_config");
		if (timed_out) return;
		execute("reuse_config");
		checker_i.end_test("reuse_config");
		if (timed_out) return;
		apply_reset();
		if (reset_stuck) return;
		for (n = 0; n < 3; n++) begin
			load_vector("reset_defaults");
		end
		execute("reset_defaults");
		checker_i.end_test("reset_defaults");
	endtask

	initial begin
		rx_valid = 1'b0;
		rx_word = '0;
		rst_req = 1'b0;
		reset_stuck = 1'b0;
		void'($urandom(SEED));
		model_reset();
		run_tests();
		checker_i.print_counts();
		if (err_count == 0 && !timed_out && !reset_stuck) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
hw/tester_pkg.sv
hw/cycle_timer.sv
hw/test_sequencer.sv
hw/vector_store.sv
hw/command_decoder.sv
hw/vector_tester_top.sv
sim/tb_clock_gen.sv
sim/tb_checker.sv
sim/tb_vector_tester.sv

//--- Bender.yml
package:
  name: vector_tester

sources:
  - files:
      - hw/tester_pkg.sv
      - hw/cycle_timer.sv
      - hw/test_sequencer.sv
      - hw/vector_store.sv
      - hw/command_decoder.sv
      - hw/vector_tester_top.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/tb_checker.sv
      - sim/tb_vector_tester.sv
